// File: design/rvvi_pkg.sv
package rvvi_pkg;

   ////////////////////////////////////////
   // Architectural widths

   typedef logic [31:0] xlen_t;
   typedef logic [63:0] order_t;
   typedef logic [31:0] insn_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [31:0] gpr_mask_t;
   typedef logic [1:0]  priv_t;

   ////////////////////////////////////////
   // Machine-mode CSR set

   localparam int NUM_CSR = 8;

   typedef logic [2:0] csr_idx_t;

   // CSR addresses in trace slot order
   localparam logic [11:0] CSR_ADDR_TABLE [NUM_CSR] = '{
      12'h300,  // mstatus
      12'h304,  // mie
      12'h305,  // mtvec
      12'h340,  // mscratch
      12'h341,  // mepc
      12'h342,  // mcause
      12'h343,  // mtval
      12'h344   // mip
   };

   ////////////////////////////////////////
   // Interrupt lines

   localparam int NUM_IRQ_LINES = 19;

   typedef logic [NUM_IRQ_LINES-1:0] irq_lines_t;
   typedef logic [31:0]              irq_t;

   // Raw irq_i bit for each compact line in MSI, MTI, MEI, local 0 to 15 order
   localparam int unsigned IRQ_RAW_BIT [NUM_IRQ_LINES] = '{
      3, 7, 11,
      16, 17, 18, 19, 20, 21, 22, 23,
      24, 25, 26, 27, 28, 29, 30, 31
   };

   ////////////////////////////////////////
   // NMI and halt request

   typedef logic [10:0] nmi_cause_t;

   localparam nmi_cause_t NMI_CAUSE_LOAD  = 11'd1024;
   localparam nmi_cause_t NMI_CAUSE_STORE = 11'd1025;

   // Cycles the halt request stays asserted after debug_req_i drops
   localparam int HALT_HOLD_CYCLES = 5;

   ////////////////////////////////////////
   // Records

   typedef struct packed {
      logic     valid;
      order_t   order;
      insn_t    insn;
      logic     trap;
      logic     intr;
      priv_t    mode;
      xlen_t    pc_rdata;
      xlen_t    pc_wdata;
      reg_idx_t rd_addr;
      xlen_t    rd_wdata;
   } rvfi_retire_s;

   typedef struct packed {
      xlen_t wdata;
      xlen_t wmask;
   } csr_wr_s;

   typedef csr_wr_s [NUM_CSR-1:0] csr_wr_array_t;

   typedef struct packed {
      logic      valid;
      order_t    order;
      insn_t     insn;
      logic      trap;
      logic      intr;
      priv_t     mode;
      xlen_t     pc_rdata;
      xlen_t     pc_wdata;
      gpr_mask_t x_wb;
      xlen_t     x_wdata;
      logic      order_err;
   } trace_retire_s;

   typedef struct packed {
      logic  [NUM_CSR-1:0] csr_wb;
      xlen_t [NUM_CSR-1:0] csr_val;
   } trace_csr_s;

   typedef struct packed {
      logic       halt_push;
      logic       halt_value;
      logic       nmi_push;
      logic       nmi_value;
      nmi_cause_t nmi_cause;
      logic       irq_push;
      irq_lines_t irq_lines;
   } net_event_s;

endpackage

// File: design/rvvi_retire_map.sv
`timescale 1ns/1ps

module rvvi_retire_map (
   input  logic                    rvvi,
   input  logic                    reset_i,
   input  rvvi_pkg::rvfi_retire_s  rvfi_i,
   output rvvi_pkg::trace_retire_s retire_o
);

   // Trace flags
   logic                valid_q;
   logic                order_err_q;
   rvvi_pkg::gpr_mask_t x_wb_q;

   // Trace payload
   rvvi_pkg::order_t    order_q;
   rvvi_pkg::insn_t     insn_q;
   logic                trap_q;
   logic                intr_q;
   rvvi_pkg::priv_t     mode_q;
   rvvi_pkg::xlen_t     pc_rdata_q;
   rvvi_pkg::xlen_t     pc_wdata_q;
   rvvi_pkg::xlen_t     x_wdata_q;

   // Order sequence state
   rvvi_pkg::order_t    last_order_q;
   logic                order_seen_q;

   rvvi_pkg::gpr_mask_t x_wb_d;
   logic                order_gap;

   ////////////////////////////////////////
   // GPR write mask

   // Writes to x0 are dropped
   always_comb begin
      x_wb_d = '0;
      if (rvfi_i.valid && (rvfi_i.rd_addr != '0)) begin
         x_wb_d[rvfi_i.rd_addr] = 1'b1;
      end
   end

   ////////////////////////////////////////
   // Order sequence check

   // No reference order before the first retirement
   assign order_gap = order_seen_q
                      && (rvfi_i.order != (last_order_q + rvvi_pkg::order_t'(1)));

   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         last_order_q <= '0;
         order_seen_q <= 1'b0;
      end else if (rvfi_i.valid) begin
         last_order_q <= rvfi_i.order;
         order_seen_q <= 1'b1;
      end
   end

   ////////////////////////////////////////
   // Trace registers

   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         valid_q     <= 1'b0;
         order_err_q <= 1'b0;
         x_wb_q      <= '0;
      end else begin
         valid_q     <= rvfi_i.valid;
         order_err_q <= rvfi_i.valid && order_gap;
         x_wb_q      <= x_wb_d;
      end
   end

   always_ff @(posedge rvvi) begin
      order_q    <= rvfi_i.order;
      insn_q     <= rvfi_i.insn;
      trap_q     <= rvfi_i.trap;
      intr_q     <= rvfi_i.intr;
      mode_q     <= rvfi_i.mode;
      pc_rdata_q <= rvfi_i.pc_rdata;
      pc_wdata_q <= rvfi_i.pc_wdata;
      x_wdata_q  <= rvfi_i.rd_wdata;
   end

   assign retire_o.valid     = valid_q;
   assign retire_o.order     = order_q;
   assign retire_o.insn      = insn_q;
   assign retire_o.trap      = trap_q;
   assign retire_o.intr      = intr_q;
   assign retire_o.mode      = mode_q;
   assign retire_o.pc_rdata  = pc_rdata_q;
   assign retire_o.pc_wdata  = pc_wdata_q;
   assign retire_o.x_wb      = x_wb_q;
   assign retire_o.x_wdata   = x_wdata_q;
   assign retire_o.order_err = order_err_q;

endmodule

// File: design/rvvi_csr_map.sv
`timescale 1ns/1ps

module rvvi_csr_map (
   input  logic                    rvvi,
   input  logic                    reset_i,
   input  logic                    rvfi_valid_i,
   input  rvvi_pkg::csr_wr_array_t csr_wr_i,
   output rvvi_pkg::trace_csr_s    csr_o
);

   rvvi_pkg::trace_csr_s csr_d;
   rvvi_pkg::trace_csr_s csr_q;

   ////////////////////////////////////////
   // Masked write values

   // Only bits named by wmask are reported, and only for a retiring instruction
   always_comb begin
      csr_d = '0;
      if (rvfi_valid_i) begin
         for (int i = 0; i < rvvi_pkg::NUM_CSR; i++) begin
            csr_d.csr_val[i] = csr_wr_i[i].wdata & csr_wr_i[i].wmask;
            // Any mask bit counts as a write-back
            csr_d.csr_wb[i]  = |csr_wr_i[i].wmask;
         end
      end
   end

   ////////////////////////////////////////
   // Output register

   // Same latency as the retirement record
   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         csr_q <= '0;
      end else begin
         csr_q <= csr_d;
      end
   end

   assign csr_o = csr_q;

endmodule

// File: design/rvvi_net_events.sv
`timescale 1ns/1ps

module rvvi_net_events (
   input  logic                 rvvi,
   input  logic                 reset_i,
   input  logic                 debug_req_i,
   input  logic                 data_err_i,
   input  logic                 data_rvalid_i,
   input  rvvi_pkg::irq_t       irq_i,
   output rvvi_pkg::net_event_s net_o
);

   typedef logic [$clog2(rvvi_pkg::HALT_HOLD_CYCLES + 1)-1:0] halt_cnt_t;

   // Event state
   halt_cnt_t            halt_cnt_q;
   halt_cnt_t            halt_cnt_d;
   logic                 data_err_q;
   rvvi_pkg::irq_lines_t irq_lines_q;

   rvvi_pkg::irq_lines_t irq_lines_d;
   rvvi_pkg::net_event_s net_d;
   rvvi_pkg::net_event_s net_q;

   ////////////////////////////////////////
   // Interrupt line compaction

   always_comb begin
      irq_lines_d = '0;
      for (int i = 0; i < rvvi_pkg::NUM_IRQ_LINES; i++) begin
         irq_lines_d[i] = irq_i[rvvi_pkg::IRQ_RAW_BIT[i][4:0]];
      end
   end

   ////////////////////////////////////////
   // Event generation

   always_comb begin
      net_d      = '0;
      halt_cnt_d = halt_cnt_q;

      // Halt request held for a few cycles after the pin drops
      if (debug_req_i) begin
         halt_cnt_d       = halt_cnt_t'(rvvi_pkg::HALT_HOLD_CYCLES);
         net_d.halt_push  = 1'b1;
         net_d.halt_value = 1'b1;
      end else if (halt_cnt_q != '0) begin
         halt_cnt_d = halt_cnt_q - halt_cnt_t'(1);
         // Release on the last step of the count
         if (halt_cnt_q == halt_cnt_t'(1)) begin
            net_d.halt_push  = 1'b1;
            net_d.halt_value = 1'b0;
         end
      end

      // NMI on either edge of data_err
      if (data_err_i != data_err_q) begin
         net_d.nmi_push  = 1'b1;
         net_d.nmi_value = data_err_i;
         if (data_err_i) begin
            // rvalid set means the error came back on a load
            net_d.nmi_cause = data_rvalid_i ? rvvi_pkg::NMI_CAUSE_LOAD
                                            : rvvi_pkg::NMI_CAUSE_STORE;
         end
      end

      // Unmapped raw bits never reach the compact vector
      if (irq_lines_d != irq_lines_q) begin
         net_d.irq_push  = 1'b1;
         net_d.irq_lines = irq_lines_d;
      end
   end

   ////////////////////////////////////////
   // State and output registers

   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         halt_cnt_q  <= '0;
         data_err_q  <= 1'b0;
         irq_lines_q <= '0;
      end else begin
         halt_cnt_q  <= halt_cnt_d;
         data_err_q  <= data_err_i;
         irq_lines_q <= irq_lines_d;
      end
   end

   always_ff @(posedge rvvi) begin
      if (reset_i) begin
         net_q <= '0;
      end else begin
         net_q <= net_d;
      end
   end

   assign net_o = net_q;

endmodule

// File: design/rvvi_trace_top.sv
`timescale 1ns/1ps

module rvvi_trace_top (
   input  logic                    rvvi,
   input  logic                    reset_i,
   input  rvvi_pkg::rvfi_retire_s  rvfi_i,
   input  rvvi_pkg::csr_wr_array_t csr_wr_i,
   input  logic                    debug_req_i,
   input  logic                    data_err_i,
   input  logic                    data_rvalid_i,
   input  rvvi_pkg::irq_t          irq_i,
   output rvvi_pkg::trace_retire_s retire_o,
   output rvvi_pkg::trace_csr_s    csr_o,
   output rvvi_pkg::net_event_s    net_o
);

   ////////////////////////////////////////
   // Retirement and CSR trace

   rvvi_retire_map rvvi_retire_map_i (
      .rvvi     (rvvi),
      .reset_i  (reset_i),
      .rvfi_i   (rvfi_i),
      .retire_o (retire_o)
   );

   // CSR writes qualified by the same retirement strobe
   rvvi_csr_map rvvi_csr_map_i (
      .rvvi         (rvvi),
      .reset_i      (reset_i),
      .rvfi_valid_i (rvfi_i.valid),
      .csr_wr_i     (csr_wr_i),
      .csr_o        (csr_o)
   );

   ////////////////////////////////////////
   // Halt, NMI and interrupt events

   rvvi_net_events rvvi_net_events_i (
      .rvvi          (rvvi),
      .reset_i       (reset_i),
      .debug_req_i   (debug_req_i),
      .data_err_i    (data_err_i),
      .data_rvalid_i (data_rvalid_i),
      .irq_i         (irq_i),
      .net_o         (net_o)
   );

endmodule

// File: dv/rvvi_trace_properties.sv
`timescale 1ns/1ps

module rvvi_trace_properties (
   input logic                    rvvi,
   input logic                    reset_i,
   input logic                    debug_req_i,
   input rvvi_pkg::trace_retire_s retire_o,
   input rvvi_pkg::trace_csr_s    csr_o,
   input rvvi_pkg::net_event_s    net_o
);

   ////////////////////////////////////////
   // GPR write mask shape

   // Never more than one register, never x0
   x_wb_onehot_a : assert property (@(posedge rvvi) disable iff (reset_i)
      $onehot0(retire_o.x_wb) && !retire_o.x_wb[0])
      else $error("x_wb is not one-hot or has x0 set");

   ////////////////////////////////////////
   // Quiet outputs after reset

   reset_quiet_a : assert property (@(posedge rvvi)
      reset_i |=> !retire_o.valid && !retire_o.order_err && (csr_o.csr_wb == '0)
                  && !net_o.halt_push && !net_o.nmi_push && !net_o.irq_push)
      else $error("Output strobe high during reset");

   ////////////////////////////////////////
   // Halt release

   // A release needs the pin low in the cycle it was sampled
   halt_release_a : assert property (@(posedge rvvi) disable iff (reset_i)
      (net_o.halt_push && !net_o.halt_value) |-> !$past(debug_req_i))
      else $error("Halt release while debug request was high");

endmodule

bind rvvi_trace_top rvvi_trace_properties rvvi_trace_properties_i (
   .rvvi        (rvvi),
   .reset_i     (reset_i),
   .debug_req_i (debug_req_i),
   .retire_o    (retire_o),
   .csr_o       (csr_o),
   .net_o       (net_o)
);

// File: dv/rvvi_trace_tb.sv
`timescale 1ns/1ps

module rvvi_trace_tb;

   localparam int NUM_CYCLES   = 400;
   localparam int RESET_CYCLES = 5;
   localparam int GAP_CYCLE    = 200;
   localparam int CLK_PERIOD   = 4;

   logic                    rvvi;
   logic                    reset_i;
   rvvi_pkg::rvfi_retire_s  rvfi_i;
   rvvi_pkg::csr_wr_array_t csr_wr_i;
   logic                    debug_req_i;
   logic                    data_err_i;
   logic                    data_rvalid_i;
   rvvi_pkg::irq_t          irq_i;
   rvvi_pkg::trace_retire_s retire_o;
   rvvi_pkg::trace_csr_s    csr_o;
   rvvi_pkg::net_event_s    net_o;

   logic [31:0]             lcg_state = 32'd19266;

   // Model state and expected outputs
   rvvi_pkg::order_t        prev_order;
   logic                    order_seen;
   int                      hold_cnt;
   logic                    prev_err;
   rvvi_pkg::irq_lines_t    prev_lines;
   rvvi_pkg::trace_retire_s exp_retire;
   rvvi_pkg::trace_csr_s    exp_csr;
   rvvi_pkg::net_event_s    exp_net;
   logic                    exp_ready = 1'b0;

   rvvi_trace_top rvvi_trace_top_i (
      .rvvi          (rvvi),
      .reset_i       (reset_i),
      .rvfi_i        (rvfi_i),
      .csr_wr_i      (csr_wr_i),
      .debug_req_i   (debug_req_i),
      .data_err_i    (data_err_i),
      .data_rvalid_i (data_rvalid_i),
      .irq_i         (irq_i),
      .retire_o      (retire_o),
      .csr_o         (csr_o),
      .net_o         (net_o)
   );

   initial begin
      rvvi = 1'b0;
      forever #(CLK_PERIOD / 2) rvvi = ~rvvi;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   ////////////////////////////////////////
   // Reference model

   function automatic rvvi_pkg::irq_lines_t compact_irq(rvvi_pkg::irq_t raw);
      return {raw[31:16], raw[11], raw[7], raw[3]};
   endfunction

   function automatic rvvi_pkg::trace_retire_s expect_retire(rvvi_pkg::rvfi_retire_s r);
      rvvi_pkg::trace_retire_s e;
      e           = '0;
      e.valid     = r.valid;
      e.order     = r.order;
      e.insn      = r.insn;
      e.trap      = r.trap;
      e.intr      = r.intr;
      e.mode      = r.mode;
      e.pc_rdata  = r.pc_rdata;
      e.pc_wdata  = r.pc_wdata;
      e.x_wdata   = r.rd_wdata;
      if (r.valid && r.rd_addr != 0) e.x_wb = 32'd1 << r.rd_addr;
      e.order_err = r.valid && order_seen && (r.order != prev_order + 64'd1);
      return e;
   endfunction

   function automatic rvvi_pkg::trace_csr_s expect_csr(logic valid,
                                                       rvvi_pkg::csr_wr_array_t w);
      rvvi_pkg::trace_csr_s e;
      e = '0;
      for (int i = 0; i < rvvi_pkg::NUM_CSR; i++) begin
         if (valid) begin
            e.csr_val[i] = w[i].wdata & w[i].wmask;
            e.csr_wb[i]  = (w[i].wmask != 0);
         end
      end
      return e;
   endfunction

   function automatic rvvi_pkg::net_event_s expect_net(logic dbg, logic err, logic rvalid,
                                                       rvvi_pkg::irq_t raw);
      rvvi_pkg::net_event_s e;
      e = '0;
      if (dbg) begin
         e.halt_push  = 1'b1;
         e.halt_value = 1'b1;
      end else if (hold_cnt == 1) begin
         e.halt_push = 1'b1;
      end
      if (err != prev_err) begin
         e.nmi_push  = 1'b1;
         e.nmi_value = err;
         if (err) e.nmi_cause = rvalid ? 11'd1024 : 11'd1025;
      end
      if (compact_irq(raw) != prev_lines) begin
         e.irq_push  = 1'b1;
         e.irq_lines = compact_irq(raw);
      end
      return e;
   endfunction

   // Expected outputs for the edge, then model state update
   always @(posedge rvvi) begin
      if (reset_i) begin
         exp_retire = '0;
         exp_csr    = '0;
         exp_net    = '0;
         prev_order = '0;
         order_seen = 1'b0;
         hold_cnt   = 0;
         prev_err   = 1'b0;
         prev_lines = '0;
      end else begin
         exp_retire = expect_retire(rvfi_i);
         exp_csr    = expect_csr(rvfi_i.valid, csr_wr_i);
         exp_net    = expect_net(debug_req_i, data_err_i, data_rvalid_i, irq_i);
         if (rvfi_i.valid) begin
            prev_order = rvfi_i.order;
            order_seen = 1'b1;
         end
         if (debug_req_i) hold_cnt = rvvi_pkg::HALT_HOLD_CYCLES;
         else if (hold_cnt > 0) hold_cnt = hold_cnt - 1;
         prev_err   = data_err_i;
         prev_lines = compact_irq(irq_i);
      end
      exp_ready = 1'b1;
   end

   ////////////////////////////////////////
   // Compare tasks

   task automatic report_mismatch(string msg);
      $display("FAILED at %0t ns: %s", $time, msg);
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatch against reference model");
   endtask

   task automatic check_retire(rvvi_pkg::trace_retire_s act, rvvi_pkg::trace_retire_s exp);
      // Payload fields only matter on a valid retirement
      if (exp.valid && act !== exp) begin
         report_mismatch($sformatf("retire order %0d got %h expected %h",
                                   exp.order, act, exp));
      end else if (act.valid !== exp.valid || act.x_wb !== exp.x_wb
                   || act.order_err !== exp.order_err) begin
         report_mismatch($sformatf("retire flags valid %b x_wb %h order_err %b",
                                   act.valid, act.x_wb, act.order_err));
      end
   endtask

   task automatic check_csr(rvvi_pkg::trace_csr_s act, rvvi_pkg::trace_csr_s exp);
      for (int i = 0; i < rvvi_pkg::NUM_CSR; i++) begin
         if (act.csr_wb[i] !== exp.csr_wb[i] || act.csr_val[i] !== exp.csr_val[i]) begin
            report_mismatch($sformatf("CSR 0x%h wb %b val %h expected wb %b val %h",
                                      rvvi_pkg::CSR_ADDR_TABLE[i], act.csr_wb[i],
                                      act.csr_val[i], exp.csr_wb[i], exp.csr_val[i]));
         end
      end
   endtask

   task automatic check_net(rvvi_pkg::net_event_s act, rvvi_pkg::net_event_s exp);
      if (act !== exp) begin
         report_mismatch($sformatf("net events got %h expected %h", act, exp));
      end
   endtask

   // Outputs are stable at the falling edge
   always @(negedge rvvi) begin
      if (exp_ready) begin
         check_retire(retire_o, exp_retire);
         check_csr(csr_o, exp_csr);
         check_net(net_o, exp_net);
      end
   end

   ////////////////////////////////////////
   // Stimulus

   task automatic drive_cycle(int cycle, inout rvvi_pkg::order_t next_order);
      logic [31:0] r;
      r                = next_rand();
      rvfi_i.valid     = (r[31:8] % 100) < 70;
      // The order gap always lands on a retirement
      if (cycle == GAP_CYCLE) rvfi_i.valid = 1'b1;
      rvfi_i.insn      = next_rand();
      rvfi_i.pc_rdata  = next_rand();
      rvfi_i.pc_wdata  = next_rand();
      rvfi_i.rd_wdata  = next_rand();
      r                = next_rand();
      rvfi_i.rd_addr   = r[12:8];
      rvfi_i.mode      = r[17:16];
      rvfi_i.trap      = r[20];
      rvfi_i.intr      = r[21];
      rvfi_i.order     = next_order;
      if (rvfi_i.valid) begin
         // One deliberate hole in the order sequence
         if (cycle == GAP_CYCLE) rvfi_i.order = next_order + 64'd7;
         next_order = rvfi_i.order + 64'd1;
      end
      for (int i = 0; i < rvvi_pkg::NUM_CSR; i++) begin
         r                 = next_rand();
         csr_wr_i[i].wdata = next_rand();
         csr_wr_i[i].wmask = (r[31:8] % 3 == 0) ? 32'd0 : next_rand();
      end
      r             = next_rand();
      debug_req_i   = (r[31:8] % 10) == 0;
      data_rvalid_i = r[5];
      if ((r[23:12] % 9) == 0) data_err_i = ~data_err_i;
      r = next_rand();
      if ((r[31:8] % 6) == 0) irq_i[r[4:0]] = ~irq_i[r[4:0]];
   endtask

   initial begin
      rvvi_pkg::order_t next_order;
      next_order    = 64'd100;
      reset_i       = 1'b1;
      rvfi_i        = '0;
      csr_wr_i      = '0;
      debug_req_i   = 1'b0;
      data_err_i    = 1'b0;
      data_rvalid_i = 1'b0;
      irq_i         = '0;
      repeat (RESET_CYCLES) @(posedge rvvi);
      #1 reset_i = 1'b0;
      for (int c = 0; c < NUM_CYCLES; c++) begin
         @(posedge rvvi);
         #1 drive_cycle(c, next_order);
      end
      @(posedge rvvi);
      #1 rvfi_i.valid = 1'b0;
      debug_req_i = 1'b0;
      repeat (8) @(posedge rvvi);
      // Let the last falling-edge compare finish first
      @(negedge rvvi);
      #1;
      $display("TESTBENCH PASSED");
      $finish;
   end

   // Watchdog
   initial begin
      #((NUM_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD * 1ns);
      $display("Timeout: the test did not reach its end in time");
      $display("TESTBENCH FAILED");
      $fatal(1, "Watchdog expired");
   end

endmodule

// File: build.f
design/rvvi_pkg.sv
design/rvvi_retire_map.sv
design/rvvi_csr_map.sv
design/rvvi_net_events.sv
design/rvvi_trace_top.sv
dv/rvvi_trace_properties.sv
dv/rvvi_trace_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the trace bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
   -f build.f \
   --top-module rvvi_trace_tb \
   -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/Vrvvi_trace_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
   exit 0
else
   echo "Pass message not found in $LOG"
   exit 1
fi
